/* fetch_defines.svh */
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

////////////////////////////////////////
// Fetch front end constants
////////////////////////////////////////

// Width of PC, addresses and instruction words
`define XLEN 32

// First fetch address after reset
// Must stay 2-byte aligned
`define RESET_PC 32'h0000_0080

`endif

/* core_pkg.sv */
`default_nettype none

package core_pkg;

    ////////////////////////////////////////
    // Next PC origin
    ////////////////////////////////////////

    // Which stage owns the next PC
    typedef enum logic [1:0] {
        PC_SEQ    = 2'b00,
        PC_JUMP   = 2'b01,
        PC_BRANCH = 2'b10
    } pc_source_t;

    ////////////////////////////////////////
    // Decoded instruction classes
    ////////////////////////////////////////

    // Major opcodes in bits 6..0
    // Both control opcodes end in 11, so compressed words never match
    typedef enum logic [6:0] {
        OP_JAL    = 7'b1101111,
        OP_BRANCH = 7'b1100011,
        // Anything else retires as a plain instruction
        OP_OTHER  = 7'b0000000
    } opcode_t;

    // Conditional branch flavours from funct3
    // BEQ is 000, BNE is 001
    typedef enum logic [1:0] {
        BR_NONE = 2'b00,
        BR_BEQ  = 2'b01,
        BR_BNE  = 2'b10
    } branch_kind_t;

endpackage

`default_nettype wire

/* redirect_if.sv */
`default_nettype none

`include "fetch_defines.svh"

// Redirect requests from the later stages to the PC controller
interface redirect_if;
    import core_pkg::*;

    // Jump resolved in ID
    logic              valid_id;
    logic [`XLEN-1:0]  jump_target_id;
    pc_source_t        pc_source_id;

    // Conditional branch resolved in EX
    logic              valid_ex;
    logic [`XLEN-1:0]  branch_target_ex;
    logic              branch_decision_ex;
    pc_source_t        pc_source_ex;

    // Driven by the ID/EX stage
    modport producer (
        output valid_id, jump_target_id, pc_source_id,
        output valid_ex, branch_target_ex, branch_decision_ex, pc_source_ex
    );

    // Read by the PC controller
    modport consumer (
        input  valid_id, jump_target_id, pc_source_id,
        input  valid_ex, branch_target_ex, branch_decision_ex, pc_source_ex
    );

endinterface

`default_nettype wire

/* pc_controller.sv */
`default_nettype none

`include "fetch_defines.svh"

module pc_controller (
    // Current fetch address
    input  wire logic [`XLEN-1:0] curr_pc_i,
    // Low bits of the fetched word say 16-bit encoding
    input  wire logic             is_compressed_i,
    // Redirect requests from ID and EX
    redirect_if.consumer          redir_i,
    // Address for the next fetch
    output logic      [`XLEN-1:0] next_pc_o
);
    import core_pkg::*;

    logic [`XLEN-1:0] seq_pc;
    logic             take_branch;
    logic             take_jump;
    pc_source_t       next_src;

    ////////////////////////////////////////
    // Sequential address
    ////////////////////////////////////////

    // Plus 2 for compressed, plus 4 otherwise
    assign seq_pc = curr_pc_i + (is_compressed_i ? `XLEN'(2) : `XLEN'(4));

    ////////////////////////////////////////
    // Redirect arbitration
    ////////////////////////////////////////

    // A redirect counts only with its valid and its own source tag
    assign take_branch = redir_i.valid_ex && (redir_i.pc_source_ex == PC_BRANCH)
                         && redir_i.branch_decision_ex;
    assign take_jump   = redir_i.valid_id && (redir_i.pc_source_id == PC_JUMP);

    // Older EX branch beats the younger ID jump
    always_comb begin
        if (take_branch) begin
            next_src = PC_BRANCH;
        end else if (take_jump) begin
            next_src = PC_JUMP;
        end else begin
            next_src = PC_SEQ;
        end
    end

    always_comb begin
        case (next_src)
            PC_BRANCH: next_pc_o = redir_i.branch_target_ex;
            PC_JUMP:   next_pc_o = redir_i.jump_target_id;
            default:   next_pc_o = seq_pc;
        endcase
    end

    // EX only ever tags branches, jumps belong to ID
    always_comb begin
        a_ex_never_jump: assert final (!redir_i.valid_ex || (redir_i.pc_source_ex != PC_JUMP))
            else $error("EX redirect tagged as jump");
    end

endmodule

`default_nettype wire

/* if_stage.sv */
`default_nettype none

`include "fetch_defines.svh"

module if_stage (
    input  wire logic             clk_i,
    input  wire logic             rst_n_i,

    // Instruction memory, read in the same cycle
    input  wire logic [`XLEN-1:0] imem_rdata_i,
    output logic      [`XLEN-1:0] imem_addr_o,

    // Towards the IF/ID register
    output logic      [`XLEN-1:0] pc_if_o,
    output logic      [`XLEN-1:0] instr_if_o,
    output logic                  valid_if_o,

    // Pipeline control
    input  wire logic             stall_if_i,
    input  wire logic             flush_if_i,

    // Redirects, handed on to the PC controller
    redirect_if.consumer          redir_i
);

    ////////////////////////////////////////
    // Program counter
    ////////////////////////////////////////

    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] pc_next;
    logic             is_compressed;

    // Holds while the pipe is stalled
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= `RESET_PC;
        end else if (!stall_if_i) begin
            pc_q <= pc_next;
        end
    end

    // Next address selection
    pc_controller pc_controller_inst (
        .curr_pc_i       ( pc_q          ),
        .is_compressed_i ( is_compressed ),
        .redir_i         ( redir_i       ),
        .next_pc_o       ( pc_next       )
    );

    ////////////////////////////////////////
    // Memory side and stage outputs
    ////////////////////////////////////////

    // 32-bit words have both low bits set
    assign is_compressed = ~(imem_rdata_i[1] & imem_rdata_i[0]);

    assign imem_addr_o = pc_q;
    assign pc_if_o     = pc_q;
    assign instr_if_o  = imem_rdata_i;

    // Bubble while stalled or when a redirect kills this fetch
    assign valid_if_o = !stall_if_i && !flush_if_i;

    // Targets and steps are all even, so bit 0 stays clear
    a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i) pc_q[0] == 1'b0)
        else $error("PC not 2-byte aligned: %h", pc_q);

endmodule

`default_nettype wire

/* if_id_reg.sv */
`default_nettype none

`include "fetch_defines.svh"

module if_id_reg (
    input  wire logic             clk_i,
    input  wire logic             rst_n_i,

    // Pipeline control
    input  wire logic             stall_i,
    input  wire logic             flush_i,

    // From IF
    input  wire logic [`XLEN-1:0] pc_i,
    input  wire logic [`XLEN-1:0] instr_i,
    input  wire logic             valid_i,

    // To ID
    output logic      [`XLEN-1:0] pc_o,
    output logic      [`XLEN-1:0] instr_o,
    output logic                  valid_o
);

    ////////////////////////////////////////
    // Valid bit
    ////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else if (!stall_i) begin
            // Flushed slot turns into a bubble
            valid_o <= valid_i && !flush_i;
        end
    end

    // Payload, only meaningful with valid_o
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            pc_o    <= pc_i;
            instr_o <= instr_i;
        end
    end

    // An unstalled flush always leaves a bubble behind
    a_flush_bubble: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (flush_i && !stall_i) |=> !valid_o)
        else $error("IF/ID valid survived a flush");

endmodule

`default_nettype wire

/* id_ex_stage.sv */
`default_nettype none

`include "fetch_defines.svh"

module id_ex_stage (
    input  wire logic             clk_i,
    input  wire logic             rst_n_i,

    // Global stall and external branch compare result
    input  wire logic             stall_i,
    input  wire logic             cond_i,

    // From the IF/ID register
    input  wire logic [`XLEN-1:0] pc_id_i,
    input  wire logic [`XLEN-1:0] instr_id_i,
    input  wire logic             valid_id_i,

    // Redirects and flushes back to the front
    redirect_if.producer          redir_o,
    output logic                  flush_if_o,
    output logic                  flush_id_o,

    // Retire port
    output logic      [`XLEN-1:0] ret_pc_o,
    output logic      [`XLEN-1:0] ret_instr_o,
    output logic                  ret_valid_o
);
    import core_pkg::*;

    // Map bits 6..0 onto the known opcodes
    function automatic opcode_t decode_op(input logic [6:0] op);
        case (op)
            7'b1101111: decode_op = OP_JAL;
            7'b1100011: decode_op = OP_BRANCH;
            default:    decode_op = OP_OTHER;
        endcase
    endfunction

    opcode_t          id_op;
    logic [`XLEN-1:0] j_imm;
    logic             jal_id;

    logic [`XLEN-1:0] ex_pc;
    logic [`XLEN-1:0] ex_instr;
    logic             ex_valid;
    opcode_t          ex_op;
    branch_kind_t     ex_kind;
    logic [`XLEN-1:0] b_imm;
    logic             taken_ex;

    ////////////////////////////////////////
    // ID: jump decode
    ////////////////////////////////////////

    assign id_op = decode_op(instr_id_i[6:0]);

    // J-type immediate, always even
    assign j_imm = {{12{instr_id_i[31]}}, instr_id_i[19:12], instr_id_i[20],
                    instr_id_i[30:21], 1'b0};

    // No redirects while stalled
    assign jal_id = valid_id_i && (id_op == OP_JAL) && !stall_i;

    assign redir_o.valid_id       = jal_id;
    assign redir_o.jump_target_id = pc_id_i + j_imm;
    assign redir_o.pc_source_id   = (id_op == OP_JAL) ? PC_JUMP : PC_SEQ;

    ////////////////////////////////////////
    // ID/EX register
    ////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_valid <= 1'b0;
        end else if (!stall_i) begin
            // Taken branch kills the ID entry on its way in
            ex_valid <= valid_id_i && !flush_id_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            ex_pc    <= pc_id_i;
            ex_instr <= instr_id_i;
        end
    end

    ////////////////////////////////////////
    // EX: branch resolution
    ////////////////////////////////////////

    assign ex_op = decode_op(ex_instr[6:0]);

    // funct3 picks BEQ or BNE, other values are not branches here
    always_comb begin
        ex_kind = BR_NONE;
        if (ex_op == OP_BRANCH) begin
            case (ex_instr[14:12])
                3'b000:  ex_kind = BR_BEQ;
                3'b001:  ex_kind = BR_BNE;
                default: ex_kind = BR_NONE;
            endcase
        end
    end

    // B-type immediate
    assign b_imm = {{20{ex_instr[31]}}, ex_instr[7], ex_instr[30:25], ex_instr[11:8], 1'b0};

    // BEQ on cond high, BNE on cond low
    assign taken_ex = ((ex_kind == BR_BEQ) && cond_i) || ((ex_kind == BR_BNE) && !cond_i);

    assign redir_o.valid_ex           = ex_valid && !stall_i;
    assign redir_o.branch_target_ex   = ex_pc + b_imm;
    assign redir_o.branch_decision_ex = taken_ex;
    assign redir_o.pc_source_ex       = (ex_kind != BR_NONE) ? PC_BRANCH : PC_SEQ;

    // Taken branch drops IF and ID, a jump drops only IF
    assign flush_id_o = ex_valid && !stall_i && taken_ex;
    assign flush_if_o = flush_id_o || jal_id;

    ////////////////////////////////////////
    // Retire
    ////////////////////////////////////////

    assign ret_valid_o = ex_valid && !stall_i;
    assign ret_pc_o    = ex_pc;
    assign ret_instr_o = ex_instr;

endmodule

`default_nettype wire

/* fetch_top.sv */
`default_nettype none

`include "fetch_defines.svh"

module fetch_top (
    input  wire logic             clk_i,
    input  wire logic             rst_n_i,

    // Global stall and branch compare flag
    input  wire logic             stall_i,
    input  wire logic             cond_i,

    // Instruction memory
    input  wire logic [`XLEN-1:0] imem_rdata_i,
    output logic      [`XLEN-1:0] imem_addr_o,

    // Retired instruction stream
    output logic      [`XLEN-1:0] ret_pc_o,
    output logic      [`XLEN-1:0] ret_instr_o,
    output logic                  ret_valid_o
);

    // Redirect bus from ID/EX back to fetch
    redirect_if redir_bus ();

    logic             flush_if;
    logic             flush_id;

    // IF to IF/ID
    logic [`XLEN-1:0] pc_if;
    logic [`XLEN-1:0] instr_if;
    logic             valid_if;

    // IF/ID to ID
    logic [`XLEN-1:0] pc_id;
    logic [`XLEN-1:0] instr_id;
    logic             valid_id;

    ////////////////////////////////////////
    // Stages
    ////////////////////////////////////////

    if_stage if_stage_inst (
        .clk_i        ( clk_i              ),
        .rst_n_i      ( rst_n_i            ),
        .imem_rdata_i ( imem_rdata_i       ),
        .imem_addr_o  ( imem_addr_o        ),
        .pc_if_o      ( pc_if              ),
        .instr_if_o   ( instr_if           ),
        .valid_if_o   ( valid_if           ),
        .stall_if_i   ( stall_i            ),
        .flush_if_i   ( flush_if           ),
        .redir_i      ( redir_bus.consumer )
    );

    if_id_reg if_id_reg_inst (
        .clk_i   ( clk_i    ),
        .rst_n_i ( rst_n_i  ),
        .stall_i ( stall_i  ),
        .flush_i ( flush_id ),
        .pc_i    ( pc_if    ),
        .instr_i ( instr_if ),
        .valid_i ( valid_if ),
        .pc_o    ( pc_id    ),
        .instr_o ( instr_id ),
        .valid_o ( valid_id )
    );

    id_ex_stage id_ex_stage_inst (
        .clk_i       ( clk_i              ),
        .rst_n_i     ( rst_n_i            ),
        .stall_i     ( stall_i            ),
        .cond_i      ( cond_i             ),
        .pc_id_i     ( pc_id              ),
        .instr_id_i  ( instr_id           ),
        .valid_id_i  ( valid_id           ),
        .redir_o     ( redir_bus.producer ),
        .flush_if_o  ( flush_if           ),
        .flush_id_o  ( flush_id           ),
        .ret_pc_o    ( ret_pc_o           ),
        .ret_instr_o ( ret_instr_o        ),
        .ret_valid_o ( ret_valid_o        )
    );

endmodule

`default_nettype wire

/* tb_fetch_top.sv */
`default_nettype none

`include "fetch_defines.svh"

module tb_fetch_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ROWS      = 16;
    localparam int MAX_IDLE  = 50;
    localparam int MEM_HALFS = 1024;

    logic             clk_i;
    logic             rst_n_i;
    logic             stall_i;
    logic             cond_i;
    logic [`XLEN-1:0] imem_rdata_i;
    logic [`XLEN-1:0] imem_addr_o;
    logic [`XLEN-1:0] ret_pc_o;
    logic [`XLEN-1:0] ret_instr_o;
    logic             ret_valid_o;

    // Program table of address, word, cond in EX and next retired PC
    // A next PC of zero ends the trace
    logic [`XLEN-1:0] tab_addr  [ROWS];
    logic [`XLEN-1:0] tab_instr [ROWS];
    logic             tab_cond  [ROWS];
    logic [`XLEN-1:0] tab_next  [ROWS];

    // Halfword instruction memory
    logic [15:0]      imem [MEM_HALFS];
    logic [`XLEN-1:0] exp_pc [$];

    fetch_top fetch_top_inst (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .stall_i      ( stall_i      ),
        .cond_i       ( cond_i       ),
        .imem_rdata_i ( imem_rdata_i ),
        .imem_addr_o  ( imem_addr_o  ),
        .ret_pc_o     ( ret_pc_o     ),
        .ret_instr_o  ( ret_instr_o  ),
        .ret_valid_o  ( ret_valid_o  )
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // Combinational read of two halfwords into one word
    always_comb begin
        imem_rdata_i = {imem[imem_addr_o[10:1] + 10'd1], imem[imem_addr_o[10:1]]};
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic [`XLEN-1:0] mem_word(input logic [`XLEN-1:0] addr);
        return {imem[addr[10:1] + 10'd1], imem[addr[10:1]]};
    endfunction

    function automatic int find_row(input logic [`XLEN-1:0] addr);
        for (int r = 0; r < ROWS; r++) begin
            if (tab_addr[r] == addr) return r;
        end
        return -1;
    endfunction

    // Conditional branch major opcode
    function automatic bit is_branch_word(input logic [`XLEN-1:0] w);
        return w[6:0] == 7'b1100011;
    endfunction

    // Idle cycles before retire n when nothing stalls
    // Fetch to retire takes 2, a jump leaves 1 bubble, a taken branch 2
    function automatic int expected_gap(input int n);
        int r;
        if (n == 0) return 2;
        r = find_row(exp_pc[n-1]);
        if (tab_instr[r][6:0] == 7'b1101111) return 1;
        if (is_branch_word(tab_instr[r]) && tab_next[r] != tab_addr[r] + 4) return 2;
        return 0;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_pc(input string name, input logic [`XLEN-1:0] exp,
                            input logic [`XLEN-1:0] act);
        if (act !== exp) begin
            stop_with_failure($sformatf("Error: %s expected %h got %h", name, exp, act));
        end
    endtask

    task automatic check_instr(input logic [`XLEN-1:0] exp, input logic [`XLEN-1:0] act);
        if (act !== exp) begin
            stop_with_failure($sformatf("Error: ret_instr_o expected %h got %h", exp, act));
        end
    endtask

    task automatic set_row(input int r, input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] w,
                           input logic c, input logic [`XLEN-1:0] nxt);
        tab_addr[r]  = a;
        tab_instr[r] = w;
        tab_cond[r]  = c;
        tab_next[r]  = nxt;
    endtask

    ////////////////////////////////////////
    // Program and reference trace
    ////////////////////////////////////////

    task automatic load_program();
        logic [`XLEN-1:0] a;
        // Fill pattern never decodes as JAL or branch
        for (int i = 0; i < MEM_HALFS; i++) begin
            a = 32'(i) << 1;
            imem[i] = {a[12:1] ^ a[31:20], 4'b0111};
        end
        set_row(0,  32'h80, 32'h0000_0013, 1'b0, 32'h84);
        set_row(1,  32'h84, 32'h0010_0093, 1'b0, 32'h88);
        set_row(2,  32'h88, 32'h0020_0113, 1'b0, 32'h8C);
        set_row(3,  32'h8C, 32'h0000_0001, 1'b0, 32'h8E);
        set_row(4,  32'h8E, 32'h0000_4501, 1'b0, 32'h90);
        set_row(5,  32'h90, 32'h0030_0193, 1'b0, 32'h94);
        // JAL +12 skips the slot at 0x98
        set_row(6,  32'h94, 32'h00C0_006F, 1'b0, 32'hA0);
        set_row(7,  32'h98, 32'h0040_0213, 1'b0, 32'h9C);
        // BEQ +16 taken on cond high
        set_row(8,  32'hA0, 32'h0000_0863, 1'b1, 32'hB0);
        set_row(9,  32'hA4, 32'h0050_0293, 1'b0, 32'hA8);
        // BNE falls through on cond high
        set_row(10, 32'hB0, 32'h0000_1863, 1'b1, 32'hB4);
        // BNE +16 taken on cond low
        set_row(11, 32'hB4, 32'h0000_1863, 1'b0, 32'hC4);
        set_row(12, 32'hB8, 32'h0060_0313, 1'b0, 32'hBC);
        // BEQ falls through on cond low
        set_row(13, 32'hC4, 32'h0000_0863, 1'b0, 32'hC8);
        set_row(14, 32'hC8, 32'h0000_0001, 1'b0, 32'hCA);
        set_row(15, 32'hCA, 32'h0070_0393, 1'b0, 32'h0);
        for (int r = 0; r < ROWS; r++) begin
            imem[tab_addr[r][10:1]] = tab_instr[r][15:0];
            // Upper half only for 32-bit encodings
            if (tab_instr[r][1:0] == 2'b11) begin
                imem[tab_addr[r][10:1] + 10'd1] = tab_instr[r][31:16];
            end
        end
    endtask

    // Follow the next-PC column from reset
    task automatic build_trace();
        logic [`XLEN-1:0] pc;
        int               r;
        pc = `RESET_PC;
        exp_pc.delete();
        while (pc != 0 && exp_pc.size() < 64) begin
            r = find_row(pc);
            if (r < 0) stop_with_failure("Reference trace left the program table");
            exp_pc.push_back(pc);
            pc = tab_next[r];
        end
    endtask

    ////////////////////////////////////////
    // One run from reset to the last retire
    ////////////////////////////////////////

    task automatic run_trace(input bit random_stall);
        int n;
        int idle;
        int r;
        rst_n_i <= 1'b0;
        stall_i <= 1'b0;
        cond_i  <= 1'b0;
        repeat (16) @(posedge clk_i);
        // Reset values of the fetch address and the retire strobe
        check_pc("imem_addr_o", `RESET_PC, imem_addr_o);
        if (ret_valid_o) stop_with_failure("Instruction retired during reset");
        rst_n_i <= 1'b1;
        n    = 0;
        idle = 0;
        while (n < exp_pc.size()) begin
            @(posedge clk_i);
            if (stall_i && ret_valid_o) stop_with_failure("Instruction retired during a stall");
            if (ret_valid_o) begin
                check_pc("ret_pc_o", exp_pc[n], ret_pc_o);
                check_instr(mem_word(exp_pc[n]), ret_instr_o);
                // Bubble count is fixed when nothing stalls
                if (!random_stall && idle != expected_gap(n)) begin
                    stop_with_failure($sformatf(
                        "Instruction retired after %0d idle cycles instead of %0d",
                        idle, expected_gap(n)));
                end
                n++;
                idle = 0;
            end else begin
                idle++;
                if (idle > MAX_IDLE) stop_with_failure("Timeout, no instruction retired");
            end
            stall_i <= random_stall ? ($urandom % 4 == 0) : 1'b0;
            // Next EX entry is the next expected retire
            // Its cond only matters for a branch
            r = (n < exp_pc.size()) ? find_row(exp_pc[n]) : -1;
            if (r >= 0 && is_branch_word(tab_instr[r])) begin
                cond_i <= tab_cond[r];
            end else begin
                cond_i <= 1'($urandom);
            end
        end
    endtask

    initial begin
        rst_n_i = 1'b0;
        stall_i = 1'b0;
        cond_i  = 1'b0;
        void'($urandom(33853));
        load_program();
        build_trace();
        run_trace(1'b0);
        run_trace(1'b1);
        run_trace(1'b1);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
core_pkg.sv
redirect_if.sv
pc_controller.sv
if_stage.sv
if_id_reg.sv
id_ex_stage.sv
fetch_top.sv
tb_fetch_top.sv
